/* Makefile */
TOP = nabp_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): tb.f *.sv
	verilator --binary --timing -j 0 --top-module $(TOP) -f tb.f

# pass only when the simulation prints the pass message
run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir

/* nabp_filter_mapper.sv */
`timescale 1ns/1ns

module nabp_filter_mapper
(
    input  logic                          clk,
    input  logic                          reset_n,
    // host write port, only used while idle
    input  nabp_pkg::sample_load_t        load,
    // read sequencing from the shifter
    input  logic                          mp_kick,
    input  logic                          mp_shift_en,
    // sample to the line buffer, valid a cycle after mp_shift_en
    output logic [nabp_pkg::SAMPLE_W-1:0] sample
);

    logic [nabp_pkg::SAMPLE_W-1:0] ram [nabp_pkg::RAM_DEPTH];
    logic [nabp_pkg::RAM_AW-1:0]   rd_addr;

    // filtered projection storage
    always_ff @(posedge clk)
    begin
        if (load.en)
            ram[load.addr] <= load.data;
    end

    // read pointer, back to the row start on each projection
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            rd_addr <= '0;
        else if (mp_kick)
            rd_addr <= '0;
        else if (mp_shift_en)
            rd_addr <= rd_addr + 1'b1;
    end

    // registered read, one cycle latency
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            sample <= '0;
        else if (mp_shift_en)
            sample <= ram[rd_addr];
    end

endmodule

/* nabp_line_buffer.sv */
`timescale 1ns/1ns

module nabp_line_buffer
(
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          lb_clear,
    input  logic                          lb_shift_en,
    // incoming sample from the mapper
    input  logic [nabp_pkg::SAMPLE_W-1:0] sample,
    // partition taps to the PEs
    output nabp_pkg::tap_vec_t            taps
);

    logic [nabp_pkg::IMAGE_SIZE-1:0][nabp_pkg::SAMPLE_W-1:0] line_q;

    // new sample at position 0, older ones move up
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            line_q <= '0;
        else if (lb_clear)
            line_q <= '0;
        else if (lb_shift_en)
            line_q <= {line_q[nabp_pkg::IMAGE_SIZE-2:0], sample};
    end

    // fixed partition positions
    assign taps[0] = line_q[nabp_pkg::PE_TAP_0];
    assign taps[1] = line_q[nabp_pkg::PE_TAP_1];
    assign taps[2] = line_q[nabp_pkg::PE_TAP_2];
    assign taps[3] = line_q[nabp_pkg::PE_TAP_3];

endmodule

/* nabp_pe_array.sv */
`timescale 1ns/1ns

module nabp_pe_array
(
    input  logic                 clk,
    input  logic                 reset_n,
    // zero all sums at the start of a run
    input  logic                 pe_clear,
    // one accumulate per shift step
    input  logic                 pe_en,
    input  nabp_pkg::tap_vec_t   taps,
    output nabp_pkg::pixel_vec_t pixels
);

    nabp_pkg::pixel_vec_t sum_q;

    // one accumulator per tap
    // sums carry over between projections unless cleared
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            sum_q <= '0;
        else if (pe_clear)
            sum_q <= '0;
        else if (pe_en)
        begin
            for (int i = 0; i < nabp_pkg::NUM_PE; i++)
            begin
                // zero-extend the unsigned sample
                sum_q[i] <= sum_q[i] + nabp_pkg::PIXEL_W'(taps[i]);
            end
        end
    end

    assign pixels = sum_q;

endmodule

/* nabp_pkg.sv */
package nabp_pkg;

    // row geometry
    localparam int IMAGE_SIZE = 16;
    localparam int NUM_PE     = 4;

    // line buffer positions feeding each PE
    localparam int PE_TAP_0 = 0;
    localparam int PE_TAP_1 = 4;
    localparam int PE_TAP_2 = 8;
    localparam int PE_TAP_3 = 12;

    // datapath widths
    localparam int SAMPLE_W  = 16;
    localparam int PIXEL_W   = 24;
    localparam int RAM_DEPTH = 32;
    localparam int RAM_AW    = 5;

    // 4.8 position accumulator
    localparam int ACCU_INT_W  = 4;
    localparam int ACCU_FRAC_W = 8;
    localparam int ACCU_W      = ACCU_INT_W + ACCU_FRAC_W;
    localparam logic [ACCU_W-1:0] ACCU_INIT = '0;

    // shifter down-counter, sized for the longer shift phase
    localparam int CNT_W = 4;
    localparam logic [CNT_W-1:0] FILL_CNT_INIT  = CNT_W'(PE_TAP_3);
    localparam logic [CNT_W-1:0] SHIFT_CNT_INIT = CNT_W'(IMAGE_SIZE - 1);

    // shifter states
    localparam int SH_STATE_W = 2;
    localparam logic [SH_STATE_W-1:0] SH_READY     = 2'd0;
    localparam logic [SH_STATE_W-1:0] SH_FILL      = 2'd1;
    localparam logic [SH_STATE_W-1:0] SH_FILL_DONE = 2'd2;
    localparam logic [SH_STATE_W-1:0] SH_SHIFT     = 2'd3;

    // projection sequencer states
    localparam int SC_STATE_W = 2;
    localparam logic [SC_STATE_W-1:0] SC_IDLE     = 2'd0;
    localparam logic [SC_STATE_W-1:0] SC_FILLING  = 2'd1;
    localparam logic [SC_STATE_W-1:0] SC_SHIFTING = 2'd2;
    localparam logic [SC_STATE_W-1:0] SC_FINISH   = 2'd3;

    // accumulator word, raw for the adder or split for the boundary test
    typedef union packed {
        logic [ACCU_W-1:0] raw;
        struct packed {
            logic [ACCU_INT_W-1:0]  int_part;
            logic [ACCU_FRAC_W-1:0] frac_part;
        } fields;
    } accu_t;

    typedef struct packed {
        logic mp_shift_en;
        logic lb_clear;
        logic lb_shift_en;
        logic pe_en;
    } shift_ctrl_t;

    typedef struct packed {
        logic                en;
        logic [RAM_AW-1:0]   addr;
        logic [SAMPLE_W-1:0] data;
    } sample_load_t;

    typedef logic [NUM_PE-1:0][SAMPLE_W-1:0] tap_vec_t;
    typedef logic [NUM_PE-1:0][PIXEL_W-1:0]  pixel_vec_t;

endpackage

/* nabp_shifter.sv */
`timescale 1ns/1ns

module nabp_shifter
(
    input  logic                  clk,
    input  logic                  reset_n,
    // kicks from the state controller
    input  logic                  fill_kick,
    input  logic                  shift_kick,
    input  nabp_pkg::accu_t       accu_base,
    // phase completion back to the state controller
    output logic                  fill_done,
    output logic                  shift_done,
    // enables to mapper, line buffer and PEs
    output nabp_pkg::shift_ctrl_t ctrl
);

    logic [nabp_pkg::SH_STATE_W-1:0] state;
    logic [nabp_pkg::SH_STATE_W-1:0] next_state;
    logic [nabp_pkg::CNT_W-1:0]      cnt;
    nabp_pkg::accu_t                 accu;
    nabp_pkg::accu_t                 accu_next;
    logic                            mp_shift_en;
    logic                            fill_done_l;
    logic                            shift_done_l;
    // delay pipes, bit 1 is the output end
    logic                            lb_shift_en_q;
    logic [1:0]                      pe_en_q;
    logic [1:0]                      fill_done_q;
    logic [1:0]                      shift_done_q;

    // wraps freely, only the integer boundary matters
    assign accu_next.raw = accu.raw + accu_base.raw;

    // every cycle in fill, only on a boundary crossing in shift
    assign mp_shift_en = (state == nabp_pkg::SH_FILL) ||
                         ((state == nabp_pkg::SH_SHIFT) &&
                          (accu_next.fields.int_part != accu.fields.int_part));

    // last cycle of each phase
    assign fill_done_l  = (cnt == '0) && (state == nabp_pkg::SH_FILL);
    assign shift_done_l = (cnt == '0) && (state == nabp_pkg::SH_SHIFT);

    // down-counter and position accumulator
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            cnt      <= nabp_pkg::FILL_CNT_INIT;
            accu.raw <= nabp_pkg::ACCU_INIT;
        end
        else
        begin
            case (state)
                nabp_pkg::SH_FILL:
                    if (cnt != '0)
                        cnt <= cnt - 1'b1;
                nabp_pkg::SH_FILL_DONE:
                    cnt <= nabp_pkg::SHIFT_CNT_INIT;
                nabp_pkg::SH_SHIFT:
                    // accumulator holds on the final step
                    if (cnt != '0)
                    begin
                        cnt      <= cnt - 1'b1;
                        accu.raw <= accu_next.raw;
                    end
                default:
                begin
                    cnt      <= nabp_pkg::FILL_CNT_INIT;
                    accu.raw <= nabp_pkg::ACCU_INIT;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= nabp_pkg::SH_READY;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            nabp_pkg::SH_READY:
                if (fill_kick)
                    next_state = nabp_pkg::SH_FILL;
            nabp_pkg::SH_FILL:
                if (fill_done_l)
                    next_state = nabp_pkg::SH_FILL_DONE;
            nabp_pkg::SH_FILL_DONE:
                if (shift_kick)
                    next_state = nabp_pkg::SH_SHIFT;
            nabp_pkg::SH_SHIFT:
                if (shift_done_l)
                    next_state = nabp_pkg::SH_READY;
            default:
                next_state = nabp_pkg::SH_READY;
        endcase
    end

    // one cycle covers the RAM read, a second the line buffer update
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            lb_shift_en_q <= 1'b0;
            pe_en_q       <= '0;
            fill_done_q   <= '0;
            shift_done_q  <= '0;
        end
        else
        begin
            lb_shift_en_q <= mp_shift_en;
            pe_en_q       <= {pe_en_q[0], state == nabp_pkg::SH_SHIFT};
            fill_done_q   <= {fill_done_q[0], fill_done_l};
            shift_done_q  <= {shift_done_q[0], shift_done_l};
        end
    end

    assign fill_done  = fill_done_q[1];
    assign shift_done = shift_done_q[1];

    // line buffer cleared at the kick, mapper restarts off the same pulse
    assign ctrl.mp_shift_en = mp_shift_en;
    assign ctrl.lb_clear    = fill_kick;
    assign ctrl.lb_shift_en = lb_shift_en_q;
    assign ctrl.pe_en       = pe_en_q[1];

endmodule

/* nabp_state_control.sv */
`timescale 1ns/1ns

module nabp_state_control
(
    input  logic clk,
    input  logic reset_n,
    // run request from outside
    input  logic start,
    input  logic clear,
    // phase completion from the shifter
    input  logic fill_done,
    input  logic shift_done,
    // phase kicks to the shifter
    output logic fill_kick,
    output logic shift_kick,
    // zero the PE sums before this run
    output logic pe_clear,
    output logic busy,
    output logic done
);

    logic [nabp_pkg::SC_STATE_W-1:0] state;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state      <= nabp_pkg::SC_IDLE;
            fill_kick  <= 1'b0;
            shift_kick <= 1'b0;
            pe_clear   <= 1'b0;
            busy       <= 1'b0;
            done       <= 1'b0;
        end
        else
        begin
            // kicks and done are single-cycle pulses
            fill_kick  <= 1'b0;
            shift_kick <= 1'b0;
            pe_clear   <= 1'b0;
            done       <= 1'b0;
            case (state)
                nabp_pkg::SC_IDLE:
                begin
                    // start only honoured here, ignored while busy
                    if (start)
                    begin
                        state     <= nabp_pkg::SC_FILLING;
                        fill_kick <= 1'b1;
                        pe_clear  <= clear;
                        busy      <= 1'b1;
                    end
                end
                nabp_pkg::SC_FILLING:
                begin
                    // buffer primed, start stepping across the row
                    if (fill_done)
                    begin
                        state      <= nabp_pkg::SC_SHIFTING;
                        shift_kick <= 1'b1;
                    end
                end
                nabp_pkg::SC_SHIFTING:
                begin
                    // last pe_en already seen, sums are final
                    if (shift_done)
                    begin
                        state <= nabp_pkg::SC_FINISH;
                        done  <= 1'b1;
                        busy  <= 1'b0;
                    end
                end
                nabp_pkg::SC_FINISH:
                    // done is high for this one cycle
                    state <= nabp_pkg::SC_IDLE;
                default:
                    state <= nabp_pkg::SC_IDLE;
            endcase
        end
    end

endmodule

/* nabp_tb.sv */
`timescale 1ns/1ns

module nabp_tb;

    localparam int NUM_ROWS     = 7;
    localparam int DONE_TIMEOUT = 200;
    localparam int BUSY_TIMEOUT = 10;
    localparam int QUIET_CYCLES = 60;

    // one stimulus row
    typedef struct packed {
        nabp_pkg::accu_t base;
        logic            clear;
        logic            start_busy;
        logic            new_samples;
    } row_t;

    logic                   clk = 1'b0;
    logic                   reset_n;
    nabp_pkg::sample_load_t load;
    logic                   start;
    logic                   clear;
    nabp_pkg::accu_t        accu_base;
    logic                   busy;
    logic                   done;
    nabp_pkg::pixel_vec_t   pixels;

    row_t                          rows [NUM_ROWS];
    logic [nabp_pkg::SAMPLE_W-1:0] samples [nabp_pkg::RAM_DEPTH];
    logic [nabp_pkg::PIXEL_W-1:0]  exp_pix [nabp_pkg::NUM_PE];
    int tap_pos [nabp_pkg::NUM_PE] = '{nabp_pkg::PE_TAP_0, nabp_pkg::PE_TAP_1,
                                       nabp_pkg::PE_TAP_2, nabp_pkg::PE_TAP_3};
    int   error_count   = 0;
    int   timeout_count = 0;
    int   done_count    = 0;
    logic timed_out     = 1'b0;

    // 4 ns period
    always #2 clk = ~clk;

    nabp_top dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .load      (load),
        .start     (start),
        .clear     (clear),
        .accu_base (accu_base),
        .busy      (busy),
        .done      (done),
        .pixels    (pixels)
    );

    // every done pulse, wanted or not
    always @(posedge done)
        done_count = done_count + 1;

    function automatic row_t make_row(input logic [nabp_pkg::ACCU_W-1:0] base,
                                      input logic clr, input logic busy_try,
                                      input logic fresh);
        row_t r;
        r.base.raw    = base;
        r.clear       = clr;
        r.start_busy  = busy_try;
        r.new_samples = fresh;
        return r;
    endfunction

    // reference: fill then boundary-driven shift, PE i sums its tap each step
    task automatic compute_expected(input nabp_pkg::accu_t base, input logic clr);
        logic [nabp_pkg::SAMPLE_W-1:0] line_m [nabp_pkg::IMAGE_SIZE];
        nabp_pkg::accu_t               acc;
        nabp_pkg::accu_t               acc_nxt;
        int                            rd;
        if (clr)
            for (int i = 0; i < nabp_pkg::NUM_PE; i++)
                exp_pix[i] = '0;
        // after fill, s[12-p] at position p, rest cleared
        for (int p = 0; p < nabp_pkg::IMAGE_SIZE; p++)
            line_m[p] = (p <= nabp_pkg::PE_TAP_3) ? samples[nabp_pkg::PE_TAP_3 - p] : '0;
        rd      = nabp_pkg::PE_TAP_3 + 1;
        acc.raw = nabp_pkg::ACCU_INIT;
        for (int k = 0; k < nabp_pkg::IMAGE_SIZE; k++)
        begin
            acc_nxt.raw = acc.raw + base.raw;
            // integer part crossing pulls in the next sample
            if (acc_nxt.fields.int_part != acc.fields.int_part)
            begin
                for (int p = nabp_pkg::IMAGE_SIZE - 1; p > 0; p--)
                    line_m[p] = line_m[p-1];
                line_m[0] = samples[rd];
                rd++;
            end
            // no advance on the final step
            if (k < nabp_pkg::IMAGE_SIZE - 1)
                acc = acc_nxt;
            for (int i = 0; i < nabp_pkg::NUM_PE; i++)
                exp_pix[i] = exp_pix[i] + nabp_pkg::PIXEL_W'(line_m[tap_pos[i]]);
        end
    endtask

    // fresh random contents for the whole RAM
    task automatic load_samples();
        logic [nabp_pkg::SAMPLE_W-1:0] word;
        for (int a = 0; a < nabp_pkg::RAM_DEPTH; a++)
        begin
            word = nabp_pkg::SAMPLE_W'($urandom);
            @(posedge clk);
            load.en   <= 1'b1;
            load.addr <= nabp_pkg::RAM_AW'(a);
            load.data <= word;
            samples[a] = word;
        end
        @(posedge clk);
        load <= '0;
    endtask

    // one-cycle start request
    task automatic pulse_start(input nabp_pkg::accu_t base, input logic clr);
        @(posedge clk);
        start     <= 1'b1;
        clear     <= clr;
        accu_base <= base;
        @(posedge clk);
        start <= 1'b0;
        clear <= 1'b0;
    endtask

    task automatic wait_busy();
        int n;
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (!busy && n < BUSY_TIMEOUT);
        if (!busy)
        begin
            $display("timeout: busy never went high after start");
            timeout_count++;
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (!done && n < DONE_TIMEOUT);
        if (!done)
        begin
            $display("timeout: done did not arrive within %0d cycles", DONE_TIMEOUT);
            timeout_count++;
            timed_out = 1'b1;
        end
    endtask

    task automatic check_pixels(input int row);
        for (int i = 0; i < nabp_pkg::NUM_PE; i++)
            if (pixels[i] !== exp_pix[i])
            begin
                $display("ERROR pixels[%0d] row %0d: got 0x%06h, expected 0x%06h",
                         i, row, pixels[i], exp_pix[i]);
                error_count++;
            end
    endtask

    initial
    begin
        int                           done_before;
        logic [nabp_pkg::PIXEL_W-1:0] flat;
        reset_n   = 1'b0;
        load      = '0;
        start     = 1'b0;
        clear     = 1'b0;
        accu_base = '0;
        void'($urandom(5676));
        for (int i = 0; i < nabp_pkg::NUM_PE; i++)
            exp_pix[i] = '0;
        // base 1.0, 0.375, 0, 0.375 again without clear, then busy starts and wrap
        rows[0] = make_row(12'h100, 1'b1, 1'b0, 1'b1);
        rows[1] = make_row(12'h060, 1'b1, 1'b0, 1'b1);
        rows[2] = make_row(12'h000, 1'b1, 1'b0, 1'b0);
        rows[3] = make_row(12'h060, 1'b0, 1'b0, 1'b0);
        rows[4] = make_row(12'h1c0, 1'b1, 1'b1, 1'b1);
        rows[5] = make_row(12'h0ab, 1'b0, 1'b1, 1'b1);
        rows[6] = make_row(12'hf80, 1'b1, 1'b0, 1'b1);
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        if (busy !== 1'b0)
        begin
            $display("ERROR busy after reset: got 0x%0h, expected 0x0", busy);
            error_count++;
        end
        if (done !== 1'b0)
        begin
            $display("ERROR done after reset: got 0x%0h, expected 0x0", done);
            error_count++;
        end
        check_pixels(-1);
        for (int r = 0; r < NUM_ROWS && !timed_out; r++)
        begin
            if (rows[r].new_samples)
                load_samples();
            @(negedge clk);
            done_before = done_count;
            pulse_start(rows[r].base, rows[r].clear);
            compute_expected(rows[r].base, rows[r].clear);
            // second request mid-run, with clear so an accepted one would show
            if (rows[r].start_busy)
            begin
                wait_busy();
                if (!timed_out)
                    pulse_start(rows[r].base, 1'b1);
            end
            if (!timed_out)
                wait_done();
            if (!timed_out)
            begin
                if (busy !== 1'b0)
                begin
                    $display("ERROR busy at done row %0d: got 0x%0h, expected 0x0", r, busy);
                    error_count++;
                end
                check_pixels(r);
                // base 0, each PE holds 16 times its post-fill tap
                if (rows[r].base.raw == '0 && rows[r].clear)
                    for (int i = 0; i < nabp_pkg::NUM_PE; i++)
                    begin
                        flat = nabp_pkg::PIXEL_W'(samples[nabp_pkg::PE_TAP_3 - tap_pos[i]]) *
                               nabp_pkg::PIXEL_W'(nabp_pkg::IMAGE_SIZE);
                        if (pixels[i] !== flat)
                        begin
                            $display("ERROR pixels[%0d] flat: got 0x%06h, expected 0x%06h",
                                     i, pixels[i], flat);
                            error_count++;
                        end
                    end
                if (rows[r].start_busy)
                    repeat (QUIET_CYCLES) @(negedge clk);
                if (done_count != done_before + 1)
                begin
                    $display("ERROR done count row %0d: got 0x%0h, expected 0x1",
                             r, done_count - done_before);
                    error_count++;
                end
            end
        end
        $display("run complete: %0d value errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

/* nabp_top.sv */
`timescale 1ns/1ns

module nabp_top
(
    input  logic                   clk,
    input  logic                   reset_n,
    // sample RAM write port
    input  nabp_pkg::sample_load_t load,
    // run handshake
    input  logic                   start,
    input  logic                   clear,
    input  nabp_pkg::accu_t        accu_base,
    output logic                   busy,
    output logic                   done,
    // accumulated pixels, stable from done
    output nabp_pkg::pixel_vec_t   pixels
);

    logic                          fill_kick;
    logic                          shift_kick;
    logic                          fill_done;
    logic                          shift_done;
    logic                          pe_clear;
    nabp_pkg::shift_ctrl_t         ctrl;
    logic [nabp_pkg::SAMPLE_W-1:0] sample;
    nabp_pkg::tap_vec_t            taps;

    // projection sequencer
    nabp_state_control u_state_control (
        .clk        (clk),
        .reset_n    (reset_n),
        .start      (start),
        .clear      (clear),
        .fill_done  (fill_done),
        .shift_done (shift_done),
        .fill_kick  (fill_kick),
        .shift_kick (shift_kick),
        .pe_clear   (pe_clear),
        .busy       (busy),
        .done       (done)
    );

    // fill and shift control
    nabp_shifter u_shifter (
        .clk        (clk),
        .reset_n    (reset_n),
        .fill_kick  (fill_kick),
        .shift_kick (shift_kick),
        .accu_base  (accu_base),
        .fill_done  (fill_done),
        .shift_done (shift_done),
        .ctrl       (ctrl)
    );

    // mapper restarts off the lb_clear copy of fill_kick
    nabp_filter_mapper u_filter_mapper (
        .clk         (clk),
        .reset_n     (reset_n),
        .load        (load),
        .mp_kick     (ctrl.lb_clear),
        .mp_shift_en (ctrl.mp_shift_en),
        .sample      (sample)
    );

    nabp_line_buffer u_line_buffer (
        .clk         (clk),
        .reset_n     (reset_n),
        .lb_clear    (ctrl.lb_clear),
        .lb_shift_en (ctrl.lb_shift_en),
        .sample      (sample),
        .taps        (taps)
    );

    nabp_pe_array u_pe_array (
        .clk      (clk),
        .reset_n  (reset_n),
        .pe_clear (pe_clear),
        .pe_en    (ctrl.pe_en),
        .taps     (taps),
        .pixels   (pixels)
    );

endmodule

/* tb.f */
nabp_pkg.sv
nabp_state_control.sv
nabp_shifter.sv
nabp_filter_mapper.sv
nabp_line_buffer.sv
nabp_pe_array.sv
nabp_top.sv
nabp_tb.sv
